//--- Makefile
# Verilator build and run for the debug-dump engine testbench

TOP = tb_saturn_debugger

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check sim.log for the pass message"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- build.f
+incdir+sim
src/saturn_dbg_pkg.sv
src/dbg_text_if.sv
src/dbg_layout_rom.sv
src/dbg_field_formatter.sv
src/dbg_text_buffer.sv
src/dbg_char_streamer.sv
src/saturn_debugger.sv
sim/tb_saturn_debugger.sv

//--- sim/tb_debugger_tasks.svh
// directed tests for the debug-dump engine, the expected-text builder
// and the value check; included inside the testbench module
`ifndef TB_DEBUGGER_TASKS_SVH
`define TB_DEBUGGER_TASKS_SVH

task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, what, actual, expected);
    end
endtask

task automatic append_text(input string s);
    for (int i = 0; i < s.len(); i++)
        expected_q.push_back(s[i]);
endtask

// most significant digit first
task automatic hex_field(input logic [63:0] value, input int digits);
    for (int i = digits - 1; i >= 0; i--)
        expected_q.push_back(hex_digits[value[4*i +: 4]]);
endtask

task automatic bit_field(input logic [15:0] value, input int width);
    for (int i = width - 1; i >= 0; i--)
        expected_q.push_back(value[i] ? 8'h31 : 8'h30);
endtask

task automatic line_break();
    expected_q.push_back(8'd10);
    expected_q.push_back(8'd13);
endtask

task automatic build_expected();
    expected_q.delete();
    line_break();
    append_text("PC: ");
    hex_field(64'(i_current_pc), 5);
    append_text(" h: ");
    append_text(i_reg_alu_mode ? "DEC" : "HEX");
    append_text(" rp: ");
    hex_field(64'(i_reg_rstk_ptr), 1);
    line_break();
    append_text("P: ");
    hex_field(64'(i_reg_p), 1);
    append_text(" HST: ");
    bit_field(16'(i_reg_hst), 4);
    append_text(" ST: ");
    bit_field(i_reg_st, 16);
    line_break();
    append_text("C: ");
    hex_field(c_val, 16);
    for (int n = 7; n >= 0; n--) begin
        line_break();
        append_text("RSTK");
        hex_field(64'(n), 1);
        append_text(": ");
        hex_field(64'(rstk_val[n]), 5);
    end
    line_break();
endtask

task automatic randomize_state();
    i_current_pc   = 20'($random(seed));
    i_reg_alu_mode = 1'($random(seed));
    i_reg_hst      = 4'($random(seed));
    i_reg_st       = 16'($random(seed));
    i_reg_p        = 4'($random(seed));
    i_reg_rstk_ptr = 3'($random(seed));
    c_val          = {32'($random(seed)), 32'($random(seed))};
    for (int n = 0; n < 8; n++)
        rstk_val[n] = 20'($random(seed));
endtask

task automatic compare_captures();
    int i;
    compare(dump_q.size(), expected_q.size(), "dump length");
    for (i = 0; i < dump_q.size() && i < expected_q.size(); i++)
        compare(dump_q[i], expected_q[i], $sformatf("dump character %0d", i));
    compare(echo_q.size(), echo_exp.size(), "echo count");
    for (i = 0; i < echo_q.size() && i < echo_exp.size(); i++)
        compare(echo_q[i], echo_exp[i], $sformatf("echo character %0d", i));
endtask

// one dump from a decode pulse to the fall of o_debug_cycle
task automatic run_dump(input bit use_busy, input bit use_echo, input bit extra_decode);
    int         cycles;
    int         stretch;
    int         toggles_before;
    bit         echo_last;
    logic [3:0] nib;
    build_expected();
    dump_q.delete();
    echo_q.delete();
    echo_exp.delete();
    toggles_before = toggle_count;
    cycles = 0;
    stretch = 0;
    echo_last = 1'b0;
    i_instr_decoded = 1'b1;
    @(negedge i_clk);
    i_instr_decoded = 1'b0;
    compare(o_debug_cycle, 1'b1, "debug cycle after decode");
    while (o_debug_cycle && cycles < DUMP_CYCLES) begin
        i_serial_busy = 1'b0;
        if (use_busy && stretch > 0) begin
            i_serial_busy = 1'b1;
            stretch--;
        end else if (use_busy && $unsigned($random(seed)) % 4 == 0) begin
            i_serial_busy = 1'b1;
            stretch = $unsigned($random(seed)) % MAX_BUSY;
        end
        i_bus_read_valid = 1'b0;
        if (use_echo && !echo_last && $unsigned($random(seed)) % 6 == 0) begin
            nib = 4'($random(seed));
            i_bus_nibble_in = nib;
            i_bus_read_valid = 1'b1;
            echo_exp.push_back(hex_digits[nib]);
        end
        echo_last = i_bus_read_valid;
        // extra decode lands while the streamer is sending the dump
        i_instr_decoded = extra_decode && (cycles == 2 * DUMP_LEN);
        @(negedge i_clk);
        cycles++;
    end
    i_serial_busy = 1'b0;
    i_bus_read_valid = 1'b0;
    i_instr_decoded = 1'b0;
    if (o_debug_cycle) begin
        error_count++;
        $display("dump did not finish within %0d cycles", DUMP_CYCLES);
    end
    // last character leaves together with the fall of o_debug_cycle
    compare(o_char_valid, 1'b1, "character with falling debug cycle");
    repeat (3) @(negedge i_clk);
    compare_captures();
    compare(toggle_count - toggles_before, dump_q.size() + echo_q.size(), "o_char_send toggles");
endtask

task automatic idle_after_reset();
    compare(o_debug_cycle, 1'b0, "o_debug_cycle after reset");
    compare(o_char_valid, 1'b0, "o_char_valid after reset");
    compare(o_char_send, 1'b0, "o_char_send after reset");
    compare(o_dbg_register, saturn_dbg_pkg::ALU_REG_NONE, "o_dbg_register after reset");
    repeat (30) @(negedge i_clk);
    compare(dump_q.size() + echo_q.size(), 0, "characters without a start");
endtask

task automatic random_dump();
    randomize_state();
    run_dump(1'b0, 1'b0, 1'b0);
endtask

task automatic mode_and_bit_fields();
    randomize_state();
    i_reg_alu_mode = 1'b0;
    i_reg_hst      = 4'hF;
    i_reg_st       = 16'hFFFF;
    run_dump(1'b0, 1'b0, 1'b0);
    i_reg_alu_mode = 1'b1;
    i_reg_hst      = 4'h4;
    i_reg_st       = 16'h0100;
    run_dump(1'b0, 1'b0, 1'b0);
endtask

task automatic busy_back_pressure();
    randomize_state();
    run_dump(1'b1, 1'b0, 1'b0);
endtask

task automatic bus_echo();
    dump_q.delete();
    echo_q.delete();
    echo_exp.delete();
    expected_q.delete();
    // every nibble value alone with an idle cycle between reads
    for (int n = 0; n < 16; n++) begin
        i_bus_nibble_in = 4'(n);
        i_bus_read_valid = 1'b1;
        echo_exp.push_back(hex_digits[n]);
        @(negedge i_clk);
        i_bus_read_valid = 1'b0;
        @(negedge i_clk);
    end
    repeat (2) @(negedge i_clk);
    compare(o_debug_cycle, 1'b0, "debug cycle during echoes");
    compare_captures();
    randomize_state();
    run_dump(1'b0, 1'b1, 1'b0);
endtask

task automatic decode_during_dump();
    randomize_state();
    run_dump(1'b0, 1'b0, 1'b1);
    repeat (20) @(negedge i_clk);
    compare(o_debug_cycle, 1'b0, "second dump after an ignored decode");
    compare(dump_q.size(), DUMP_LEN, "characters after an ignored decode");
endtask

`endif

//--- sim/tb_saturn_debugger.sv
// testbench for the debug-dump engine: cpu state model, character capture,
// timeout and the directed tests from tb_debugger_tasks.svh
`timescale 1ns/1ns

module tb_saturn_debugger;

    localparam int DUMP_LEN       = 196;
    localparam int NUM_DUMPS      = 6;
    localparam int MAX_BUSY       = 8;
    // worst case per dump: formatting plus every character behind a full busy stretch
    localparam int DUMP_CYCLES    = DUMP_LEN * (3 + MAX_BUSY) * 2;
    localparam int TIMEOUT_CYCLES = NUM_DUMPS * DUMP_CYCLES + 2000;

    logic        i_clk;
    logic        i_reset;
    logic        i_instr_decoded;
    logic [19:0] i_current_pc;
    logic        i_reg_alu_mode;
    logic [3:0]  i_reg_hst;
    logic [15:0] i_reg_st;
    logic [3:0]  i_reg_p;
    logic [2:0]  i_reg_rstk_ptr;
    logic [3:0]  i_dbg_reg_nibble;
    logic [19:0] i_dbg_rstk_val;
    logic        i_serial_busy;
    logic [3:0]  i_bus_nibble_in;
    logic        i_bus_read_valid;
    logic        o_debug_cycle;
    logic [4:0]  o_dbg_register;
    logic [3:0]  o_dbg_reg_ptr;
    logic [2:0]  o_dbg_rstk_ptr;
    logic [7:0]  o_char_to_send;
    logic        o_char_valid;
    logic        o_char_send;

    // cpu register file as seen through the debug port
    logic [63:0] c_val;
    logic [19:0] rstk_val [8];

    integer      seed;
    int          error_count;
    int          check_count;
    int          cycle_count;
    int          toggle_count;
    logic        last_send;
    logic        busy_at_edge;
    logic        echo_at_edge;
    logic [7:0]  dump_q[$];
    logic [7:0]  echo_q[$];
    logic [7:0]  expected_q[$];
    logic [7:0]  echo_exp[$];
    string       hex_digits = "0123456789ABCDEF";

    `include "tb_debugger_tasks.svh"

    saturn_debugger #(.BUF_DEPTH(512)) saturn_debugger_i (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_instr_decoded  (i_instr_decoded),
        .o_debug_cycle    (o_debug_cycle),
        .i_current_pc     (i_current_pc),
        .i_reg_alu_mode   (i_reg_alu_mode),
        .i_reg_hst        (i_reg_hst),
        .i_reg_st         (i_reg_st),
        .i_reg_p          (i_reg_p),
        .i_reg_rstk_ptr   (i_reg_rstk_ptr),
        .o_dbg_register   (o_dbg_register),
        .o_dbg_reg_ptr    (o_dbg_reg_ptr),
        .o_dbg_rstk_ptr   (o_dbg_rstk_ptr),
        .i_dbg_reg_nibble (i_dbg_reg_nibble),
        .i_dbg_rstk_val   (i_dbg_rstk_val),
        .o_char_to_send   (o_char_to_send),
        .o_char_valid     (o_char_valid),
        .o_char_send      (o_char_send),
        .i_serial_busy    (i_serial_busy),
        .i_bus_nibble_in  (i_bus_nibble_in),
        .i_bus_read_valid (i_bus_read_valid)
    );

    // combinational register reads, same cycle
    assign i_dbg_reg_nibble = (o_dbg_register == saturn_dbg_pkg::ALU_REG_C) ?
                              c_val[4*o_dbg_reg_ptr +: 4] : 4'h0;
    assign i_dbg_rstk_val   = rstk_val[o_dbg_rstk_ptr];

    initial i_clk = 1'b0;
    always #10 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // what the streamer saw at the edge that launched each character
    always @(posedge i_clk) begin
        busy_at_edge <= i_serial_busy;
        echo_at_edge <= i_bus_read_valid;
    end

    always @(negedge i_clk) begin
        if (o_char_send != last_send)
            toggle_count++;
        last_send = o_char_send;
        if (o_char_valid === 1'b1) begin
            if (echo_at_edge) begin
                echo_q.push_back(o_char_to_send);
            end else begin
                dump_q.push_back(o_char_to_send);
                compare(busy_at_edge, 1'b0, "dump character sent while serial busy");
            end
        end
    end

    initial begin
        seed             = 46;
        last_send        = 1'b0;
        i_reset          = 1'b1;
        i_instr_decoded  = 1'b0;
        i_current_pc     = '0;
        i_reg_alu_mode   = 1'b0;
        i_reg_hst        = '0;
        i_reg_st         = '0;
        i_reg_p          = '0;
        i_reg_rstk_ptr   = '0;
        i_serial_busy    = 1'b0;
        i_bus_nibble_in  = '0;
        i_bus_read_valid = 1'b0;
        c_val            = '0;
        for (int n = 0; n < 8; n++)
            rstk_val[n] = '0;
        repeat (16) @(negedge i_clk);
        i_reset = 1'b0;

        idle_after_reset();
        random_dump();
        mode_and_bit_fields();
        busy_back_pressure();
        bus_echo();
        decode_during_dump();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- src/dbg_char_streamer.sv
// sends the buffered dump to the serial port, one character per strobe,
// holding back on busy; bus nibble echoes always go first
`timescale 1ns/1ns

module dbg_char_streamer #(
    parameter int BUF_DEPTH = 512
) (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         i_start,
    input  logic [$clog2(BUF_DEPTH)-1:0] i_last_addr,
    input  logic                         i_serial_busy,
    input  saturn_dbg_pkg::nibble_t      i_bus_nibble_in,
    input  logic                         i_bus_read_valid,
    dbg_text_if.reader                   text,
    output saturn_dbg_pkg::dbg_char_t    o_char_to_send,
    output logic                         o_char_valid,
    output logic                         o_char_send,
    output logic                         o_send_done
);
    localparam int AW = $clog2(BUF_DEPTH);

    logic          active;
    // rd_data already holds the character at rd_addr
    logic          ready;
    logic [AW-1:0] rd_addr;
    logic          dump_send;
    logic          last_char;

    assign text.rd_addr = rd_addr;
    assign last_char    = (rd_addr == i_last_addr);
    assign dump_send    = active && ready && !i_serial_busy && !o_char_valid &&
                          !i_bus_read_valid;
    assign o_send_done  = dump_send && last_char;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            active       <= 1'b0;
            ready        <= 1'b0;
            rd_addr      <= '0;
            o_char_valid <= 1'b0;
            o_char_send  <= 1'b0;
        end else begin
            o_char_valid <= i_bus_read_valid || dump_send;
            if (i_bus_read_valid || dump_send)
                o_char_send <= ~o_char_send;

            if (i_start) begin
                active  <= 1'b1;
                ready   <= 1'b0;
                rd_addr <= '0;
            end else if (dump_send) begin
                // next address is fetched while the strobe is out
                ready <= 1'b0;
                if (last_char)
                    active <= 1'b0;
                else
                    rd_addr <= rd_addr + 1'b1;
            end else if (active) begin
                ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_bus_read_valid)
            o_char_to_send <= saturn_dbg_pkg::hex_char(i_bus_nibble_in);
        else if (dump_send)
            o_char_to_send <= text.rd_data;
    end

endmodule

//--- src/dbg_field_formatter.sv
// walks the layout table and writes the dump text, one character per cycle
// register C and the return stack are read through the cpu debug port
`timescale 1ns/1ns

module dbg_field_formatter #(
    parameter int BUF_DEPTH = 512
) (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         i_start,
    input  saturn_dbg_pkg::pc_t          i_current_pc,
    input  logic                         i_reg_alu_mode,
    input  saturn_dbg_pkg::nibble_t      i_reg_hst,
    input  logic [15:0]                  i_reg_st,
    input  saturn_dbg_pkg::nibble_t      i_reg_p,
    input  logic [2:0]                   i_reg_rstk_ptr,
    output saturn_dbg_pkg::seg_idx_t     o_seg,
    input  saturn_dbg_pkg::seg_kind_t    i_kind,
    input  saturn_dbg_pkg::label_t       i_label,
    input  logic [2:0]                   i_label_len,
    output saturn_dbg_pkg::alu_reg_t     o_dbg_register,
    output saturn_dbg_pkg::nibble_t      o_dbg_reg_ptr,
    output logic [2:0]                   o_dbg_rstk_ptr,
    input  saturn_dbg_pkg::nibble_t      i_dbg_reg_nibble,
    input  saturn_dbg_pkg::pc_t          i_dbg_rstk_val,
    dbg_text_if.writer                   text,
    output logic                         o_done,
    output logic [$clog2(BUF_DEPTH)-1:0] o_last_addr
);
    localparam int AW = $clog2(BUF_DEPTH);

    logic                      running;
    logic [3:0]                ptr;
    logic [2:0]                entry;
    logic [AW-1:0]             addr;
    logic [4:0]                seg_len;
    logic                      seg_last;
    logic                      wr_en;
    saturn_dbg_pkg::label_t    lbl_sh;
    saturn_dbg_pkg::pc_t       pc_sh;
    saturn_dbg_pkg::pc_t       rstk_sh;
    logic [3:0]                hst_sh;
    logic [15:0]               st_sh;
    saturn_dbg_pkg::dbg_char_t ch;

    // current character always lands in the top bits
    assign lbl_sh  = i_label << (8 * (saturn_dbg_pkg::LABEL_MAX - i_label_len + ptr));
    assign pc_sh   = i_current_pc << (4 * ptr);
    assign rstk_sh = i_dbg_rstk_val << (4 * (ptr - 4'd3));
    assign hst_sh  = i_reg_hst << ptr;
    assign st_sh   = i_reg_st << ptr;

    always_comb begin
        case (i_kind)
            saturn_dbg_pkg::SEG_NEWLINE:  seg_len = 5'd2;
            saturn_dbg_pkg::SEG_LABEL:    seg_len = {2'b00, i_label_len};
            saturn_dbg_pkg::SEG_HEX_PC:   seg_len = 5'd5;
            saturn_dbg_pkg::SEG_MODE:     seg_len = 5'd3;
            saturn_dbg_pkg::SEG_BIN_HST:  seg_len = 5'd4;
            saturn_dbg_pkg::SEG_BIN_ST,
            saturn_dbg_pkg::SEG_HEX_C:    seg_len = 5'd16;
            // digit, ": " and five nibbles
            saturn_dbg_pkg::SEG_HEX_RSTK: seg_len = 5'd8;
            default:                      seg_len = 5'd1;
        endcase
    end

    assign seg_last = ({1'b0, ptr} == seg_len - 5'd1);

    always_comb begin
        ch = " ";
        case (i_kind)
            saturn_dbg_pkg::SEG_NEWLINE: ch = (ptr == 4'd0) ? 8'd10 : 8'd13;
            saturn_dbg_pkg::SEG_LABEL:   ch = lbl_sh[saturn_dbg_pkg::LABEL_MAX*8-1 -: 8];
            saturn_dbg_pkg::SEG_HEX_PC:  ch = saturn_dbg_pkg::hex_char(pc_sh[19:16]);
            saturn_dbg_pkg::SEG_MODE: begin
                if (ptr == 4'd1)
                    ch = "E";
                else if (ptr == 4'd0)
                    ch = i_reg_alu_mode ? "D" : "H";
                else
                    ch = i_reg_alu_mode ? "C" : "X";
            end
            saturn_dbg_pkg::SEG_HEX_RP:  ch = saturn_dbg_pkg::hex_char({1'b0, i_reg_rstk_ptr});
            saturn_dbg_pkg::SEG_HEX_P:   ch = saturn_dbg_pkg::hex_char(i_reg_p);
            saturn_dbg_pkg::SEG_BIN_HST: ch = hst_sh[3] ? "1" : "0";
            saturn_dbg_pkg::SEG_BIN_ST:  ch = st_sh[15] ? "1" : "0";
            saturn_dbg_pkg::SEG_HEX_C:   ch = saturn_dbg_pkg::hex_char(i_dbg_reg_nibble);
            saturn_dbg_pkg::SEG_HEX_RSTK: begin
                case (ptr)
                    4'd0:    ch = saturn_dbg_pkg::hex_char({1'b0, entry});
                    4'd1:    ch = ":";
                    4'd2:    ch = " ";
                    default: ch = saturn_dbg_pkg::hex_char(rstk_sh[19:16]);
                endcase
            end
            default:                     ch = " ";
        endcase
    end

    // C is only selected while its nibbles are printed
    assign o_dbg_register = (running && i_kind == saturn_dbg_pkg::SEG_HEX_C) ?
                            saturn_dbg_pkg::ALU_REG_C : saturn_dbg_pkg::ALU_REG_NONE;
    assign o_dbg_reg_ptr  = ~ptr;
    assign o_dbg_rstk_ptr = entry;

    assign wr_en         = running && (i_kind != saturn_dbg_pkg::SEG_END);
    assign text.wr_en    = wr_en;
    assign text.wr_addr  = addr;
    assign text.wr_data  = ch;
    assign o_done        = running && (i_kind == saturn_dbg_pkg::SEG_END);

    always_ff @(posedge i_clk) begin
        if (i_reset || i_start) begin
            running <= i_start && !i_reset;
            o_seg   <= '0;
            ptr     <= 4'd0;
            entry   <= 3'd7;
            addr    <= '0;
        end else if (o_done) begin
            running <= 1'b0;
        end else if (running) begin
            addr <= addr + 1'b1;
            if (!seg_last) begin
                ptr <= ptr + 4'd1;
            end else begin
                ptr <= 4'd0;
                // back to the newline ahead of the RSTK label
                if (i_kind == saturn_dbg_pkg::SEG_HEX_RSTK && entry != 3'd0) begin
                    entry <= entry - 3'd1;
                    o_seg <= o_seg - 6'd2;
                end else begin
                    o_seg <= o_seg + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en)
            o_last_addr <= addr;
    end

endmodule

//--- src/dbg_layout_rom.sv
// ordered list of dump segments, looked up by segment index
// the formatter walks it from index 0 until it meets SEG_END
`timescale 1ns/1ns

module dbg_layout_rom (
    input  saturn_dbg_pkg::seg_idx_t  i_seg,
    output saturn_dbg_pkg::seg_kind_t o_kind,
    output saturn_dbg_pkg::label_t    o_label,
    output logic [2:0]                o_label_len
);

    always_comb begin
        o_kind      = saturn_dbg_pkg::SEG_END;
        o_label     = '0;
        o_label_len = 3'd0;
        case (i_seg)
            // PC, mode and return-stack pointer
            6'd0:  o_kind = saturn_dbg_pkg::SEG_NEWLINE;
            6'd1: begin
                o_kind      = saturn_dbg_pkg::SEG_LABEL;
                o_label     = saturn_dbg_pkg::label_t'("PC: ");
                o_label_len = 3'd4;
            end
            6'd2:  o_kind = saturn_dbg_pkg::SEG_HEX_PC;
            6'd3: begin
                o_kind      = saturn_dbg_pkg::SEG_LABEL;
                o_label     = saturn_dbg_pkg::label_t'(" h: ");
                o_label_len = 3'd4;
            end
            6'd4:  o_kind = saturn_dbg_pkg::SEG_MODE;
            6'd5: begin
                o_kind      = saturn_dbg_pkg::SEG_LABEL;
                o_label     = saturn_dbg_pkg::label_t'(" rp: ");
                o_label_len = 3'd5;
            end
            6'd6:  o_kind = saturn_dbg_pkg::SEG_HEX_RP;
            // P and status bits
            6'd7:  o_kind = saturn_dbg_pkg::SEG_NEWLINE;
            6'd8: begin
                o_kind      = saturn_dbg_pkg::SEG_LABEL;
                o_label     = saturn_dbg_pkg::label_t'("P: ");
                o_label_len = 3'd3;
            end
            6'd9:  o_kind = saturn_dbg_pkg::SEG_HEX_P;
            6'd10: begin
                o_kind      = saturn_dbg_pkg::SEG_LABEL;
                o_label     = saturn_dbg_pkg::label_t'(" HST: ");
                o_label_len = 3'd6;
            end
            6'd11: o_kind = saturn_dbg_pkg::SEG_BIN_HST;
            6'd12: begin
                o_kind      = saturn_dbg_pkg::SEG_LABEL;
                o_label     = saturn_dbg_pkg::label_t'(" ST: ");
                o_label_len = 3'd5;
            end
            6'd13: o_kind = saturn_dbg_pkg::SEG_BIN_ST;
            // register C
            6'd14: o_kind = saturn_dbg_pkg::SEG_NEWLINE;
            6'd15: begin
                o_kind      = saturn_dbg_pkg::SEG_LABEL;
                o_label     = saturn_dbg_pkg::label_t'("C: ");
                o_label_len = 3'd3;
            end
            6'd16: o_kind = saturn_dbg_pkg::SEG_HEX_C;
            // one RSTK line, repeated by the formatter for entries 7..0
            6'd17: o_kind = saturn_dbg_pkg::SEG_NEWLINE;
            6'd18: begin
                o_kind      = saturn_dbg_pkg::SEG_LABEL;
                o_label     = saturn_dbg_pkg::label_t'("RSTK");
                o_label_len = 3'd4;
            end
            6'd19: o_kind = saturn_dbg_pkg::SEG_HEX_RSTK;
            6'd20: o_kind = saturn_dbg_pkg::SEG_NEWLINE;
            default: o_kind = saturn_dbg_pkg::SEG_END;
        endcase
    end

endmodule

//--- src/dbg_text_buffer.sv
// character memory for one dump, written by the formatter and read by the
// streamer with one cycle of read latency
`timescale 1ns/1ns

module dbg_text_buffer #(
    parameter int BUF_DEPTH = 512
) (
    input  logic   i_clk,
    dbg_text_if.mem text
);

    saturn_dbg_pkg::dbg_char_t mem_q [BUF_DEPTH];

    always_ff @(posedge i_clk) begin
        if (text.wr_en)
            mem_q[text.wr_addr] <= text.wr_data;
        text.rd_data <= mem_q[text.rd_addr];
    end

endmodule

//--- src/dbg_text_if.sv
// character buffer port bundle: the formatter writes, the streamer reads
// reads return data one cycle after the address is presented
`timescale 1ns/1ns

interface dbg_text_if #(
    parameter int BUF_DEPTH = 512
);
    localparam int AW = $clog2(BUF_DEPTH);

    logic                      wr_en;
    logic [AW-1:0]             wr_addr;
    saturn_dbg_pkg::dbg_char_t wr_data;
    logic [AW-1:0]             rd_addr;
    saturn_dbg_pkg::dbg_char_t rd_data;

    modport writer (output wr_en, wr_addr, wr_data);
    modport reader (output rd_addr, input rd_data);
    modport mem (input wr_en, wr_addr, wr_data, rd_addr, output rd_data);

endinterface

//--- src/saturn_dbg_pkg.sv
// shared types, register codes and segment kinds for the debug-dump engine
// design files refer to everything here by scoped name
package saturn_dbg_pkg;

    // one ascii character on the serial side
    typedef logic [7:0] dbg_char_t;
    typedef logic [3:0] nibble_t;

    // 20-bit address, pc and return-stack entries alike
    typedef logic [19:0] pc_t;

    // register selector understood by the cpu register file
    typedef logic [4:0] alu_reg_t;
    localparam alu_reg_t ALU_REG_C    = 5'd2;
    localparam alu_reg_t ALU_REG_NONE = 5'd31;

    // what a layout segment prints
    typedef enum logic [3:0] {
        SEG_NEWLINE,
        SEG_LABEL,
        SEG_HEX_PC,
        SEG_MODE,
        SEG_HEX_RP,
        SEG_HEX_P,
        SEG_BIN_HST,
        SEG_BIN_ST,
        SEG_HEX_C,
        SEG_HEX_RSTK,
        SEG_END
    } seg_kind_t;

    localparam int LABEL_MAX = 7;

    // right aligned: the first character sits in the highest used byte
    typedef logic [LABEL_MAX*8-1:0] label_t;

    typedef logic [5:0] seg_idx_t;

    // "0".."9" then "A".."F"
    function automatic dbg_char_t hex_char(input nibble_t n);
        if (n < 4'd10)
            return 8'h30 + {4'd0, n};
        return 8'h37 + {4'd0, n};
    endfunction

endpackage

//--- src/saturn_debugger.sv
// debug-dump engine top: a decoded instruction while idle snapshots the cpu
// state as text and streams it out; bus nibble reads are echoed as hex
`timescale 1ns/1ns

module saturn_debugger #(
    parameter int BUF_DEPTH = 512
) (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_instr_decoded,
    output logic                      o_debug_cycle,
    // cpu state, stable for the whole dump
    input  saturn_dbg_pkg::pc_t       i_current_pc,
    input  logic                      i_reg_alu_mode,
    input  saturn_dbg_pkg::nibble_t   i_reg_hst,
    input  logic [15:0]               i_reg_st,
    input  saturn_dbg_pkg::nibble_t   i_reg_p,
    input  logic [2:0]                i_reg_rstk_ptr,
    // register read port, answered in the same cycle
    output saturn_dbg_pkg::alu_reg_t  o_dbg_register,
    output saturn_dbg_pkg::nibble_t   o_dbg_reg_ptr,
    output logic [2:0]                o_dbg_rstk_ptr,
    input  saturn_dbg_pkg::nibble_t   i_dbg_reg_nibble,
    input  saturn_dbg_pkg::pc_t       i_dbg_rstk_val,
    // serial transmitter
    output saturn_dbg_pkg::dbg_char_t o_char_to_send,
    output logic                      o_char_valid,
    output logic                      o_char_send,
    input  logic                      i_serial_busy,
    input  saturn_dbg_pkg::nibble_t   i_bus_nibble_in,
    input  logic                      i_bus_read_valid
);
    localparam int AW = $clog2(BUF_DEPTH);

    logic                      start;
    logic                      fmt_done;
    logic [AW-1:0]             fmt_last_addr;
    logic                      send_done;
    saturn_dbg_pkg::seg_idx_t  seg;
    saturn_dbg_pkg::seg_kind_t seg_kind;
    saturn_dbg_pkg::label_t    seg_label;
    logic [2:0]                seg_label_len;

    dbg_text_if #(.BUF_DEPTH(BUF_DEPTH)) text_bus ();

    // new decodes are ignored until the current dump has left
    assign start = i_instr_decoded && !o_debug_cycle;

    always_ff @(posedge i_clk) begin
        if (i_reset)
            o_debug_cycle <= 1'b0;
        else if (start)
            o_debug_cycle <= 1'b1;
        else if (send_done)
            o_debug_cycle <= 1'b0;
    end

    dbg_layout_rom layout_rom_i (
        .i_seg       (seg),
        .o_kind      (seg_kind),
        .o_label     (seg_label),
        .o_label_len (seg_label_len)
    );

    dbg_field_formatter #(.BUF_DEPTH(BUF_DEPTH)) formatter_i (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_start          (start),
        .i_current_pc     (i_current_pc),
        .i_reg_alu_mode   (i_reg_alu_mode),
        .i_reg_hst        (i_reg_hst),
        .i_reg_st         (i_reg_st),
        .i_reg_p          (i_reg_p),
        .i_reg_rstk_ptr   (i_reg_rstk_ptr),
        .o_seg            (seg),
        .i_kind           (seg_kind),
        .i_label          (seg_label),
        .i_label_len      (seg_label_len),
        .o_dbg_register   (o_dbg_register),
        .o_dbg_reg_ptr    (o_dbg_reg_ptr),
        .o_dbg_rstk_ptr   (o_dbg_rstk_ptr),
        .i_dbg_reg_nibble (i_dbg_reg_nibble),
        .i_dbg_rstk_val   (i_dbg_rstk_val),
        .text             (text_bus.writer),
        .o_done           (fmt_done),
        .o_last_addr      (fmt_last_addr)
    );

    dbg_text_buffer #(.BUF_DEPTH(BUF_DEPTH)) text_buffer_i (
        .i_clk (i_clk),
        .text  (text_bus.mem)
    );

    dbg_char_streamer #(.BUF_DEPTH(BUF_DEPTH)) streamer_i (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_start          (fmt_done),
        .i_last_addr      (fmt_last_addr),
        .i_serial_busy    (i_serial_busy),
        .i_bus_nibble_in  (i_bus_nibble_in),
        .i_bus_read_valid (i_bus_read_valid),
        .text             (text_bus.reader),
        .o_char_to_send   (o_char_to_send),
        .o_char_valid     (o_char_valid),
        .o_char_send      (o_char_send),
        .o_send_done      (send_done)
    );

endmodule
